//--- hw/cdc_fifo_gray.sv
// Needs LogDepth of at least 1 and SyncStages of at least 1 with first-word fall-through read data
`timescale 1ns/1ps

module cdc_fifo_gray #(
  parameter int unsigned LogDepth   = 3,
  parameter int unsigned SyncStages = 2,
  parameter type         data_t     = logic
) (
  // Write domain
  input  logic  wr_clk_i,
  input  logic  wr_rst_n_i,
  input  logic  push_i,
  input  data_t data_i,
  output logic  full_o,
  // Read domain
  input  logic  rd_clk_i,
  input  logic  rd_rst_n_i,
  input  logic  pop_i,
  output logic  empty_o,
  output data_t data_o
);

  localparam int unsigned Depth    = 2 ** LogDepth;
  localparam int unsigned PtrWidth = LogDepth + 1;
  // Gray pattern of a pointer one full lap ahead
  localparam logic [LogDepth:0] FullMask = PtrWidth'(3) << (LogDepth - 1);

  typedef logic [LogDepth:0] ptr_t;

  data_t mem_q [Depth];
  ptr_t  wr_bin_q, wr_bin_d, wr_gray_q, wr_gray_d;
  ptr_t  rd_bin_q, rd_bin_d, rd_gray_q, rd_gray_d;
  ptr_t  rd_gray_sync_q [SyncStages];
  ptr_t  wr_gray_sync_q [SyncStages];
  logic  full_q;
  logic  empty_q;
  logic  do_push;
  logic  do_pop;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  assign do_push   = push_i && !full_q;
  assign wr_bin_d  = wr_bin_q + PtrWidth'(do_push);
  assign wr_gray_d = bin2gray(wr_bin_d);

  assign do_pop    = pop_i && !empty_q;
  assign rd_bin_d  = rd_bin_q + PtrWidth'(do_pop);
  assign rd_gray_d = bin2gray(rd_bin_d);

  always_ff @(posedge wr_clk_i) begin
    if (do_push) begin
      mem_q[wr_bin_q[LogDepth-1:0]] <= data_i;
    end
  end

  always_ff @(posedge wr_clk_i) begin
    if (!wr_rst_n_i) begin
      wr_bin_q       <= '0;
      wr_gray_q      <= '0;
      full_q         <= 1'b0;
      rd_gray_sync_q <= '{default: '0};
    end else begin
      wr_bin_q          <= wr_bin_d;
      wr_gray_q         <= wr_gray_d;
      full_q            <= (wr_gray_d == (rd_gray_sync_q[SyncStages-1] ^ FullMask));
      rd_gray_sync_q[0] <= rd_gray_q;
      for (int i = 1; i < SyncStages; i++) begin
        rd_gray_sync_q[i] <= rd_gray_sync_q[i-1];
      end
    end
  end

  always_ff @(posedge rd_clk_i) begin
    if (!rd_rst_n_i) begin
      rd_bin_q       <= '0;
      rd_gray_q      <= '0;
      empty_q        <= 1'b1;
      wr_gray_sync_q <= '{default: '0};
    end else begin
      rd_bin_q          <= rd_bin_d;
      rd_gray_q         <= rd_gray_d;
      empty_q           <= (rd_gray_d == wr_gray_sync_q[SyncStages-1]);
      wr_gray_sync_q[0] <= wr_gray_q;
      for (int i = 1; i < SyncStages; i++) begin
        wr_gray_sync_q[i] <= wr_gray_sync_q[i-1];
      end
    end
  end

  assign full_o  = full_q;
  assign empty_o = empty_q;
  assign data_o  = mem_q[rd_bin_q[LogDepth-1:0]];

endmodule

//--- hw/wb_cdc_bridge.sv
// Host port on clk_i and target port on dst_clk_i with each domain reset on its own
`timescale 1ns/1ps

module wb_cdc_bridge #(
  parameter int unsigned LogDepth   = 3,
  parameter int unsigned SyncStages = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             dst_clk_i,
  input  logic                             dst_rst_n_i,
  // Isolation control
  input  logic                             isolate_i,
  output logic                             isolated_o,
  // Host side Wishbone slave
  input  logic                             cyc_i,
  input  logic                             stb_i,
  input  logic                             we_i,
  input  logic [wb_cdc_pkg::AddrWidth-1:0] adr_i,
  input  logic [wb_cdc_pkg::DataWidth-1:0] dat_i,
  input  logic [wb_cdc_pkg::SelWidth-1:0]  sel_i,
  output logic                             ack_o,
  output logic                             err_o,
  output logic [wb_cdc_pkg::DataWidth-1:0] dat_o,
  // Target side Wishbone master
  output logic                             dst_cyc_o,
  output logic                             dst_stb_o,
  output logic                             dst_we_o,
  output logic [wb_cdc_pkg::AddrWidth-1:0] dst_adr_o,
  output logic [wb_cdc_pkg::DataWidth-1:0] dst_dat_o,
  output logic [wb_cdc_pkg::SelWidth-1:0]  dst_sel_o,
  input  logic                             dst_ack_i,
  input  logic                             dst_err_i,
  input  logic [wb_cdc_pkg::DataWidth-1:0] dst_dat_i
);
  import wb_cdc_pkg::*;

  // Request path
  logic    req_push, req_full, req_pop, req_empty;
  wb_req_t src_req, dst_req;

  // Response path
  logic    rsp_push, rsp_full, rsp_pop, rsp_empty;
  wb_rsp_t src_rsp, dst_rsp;

  wb_isolate_src u_src (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .isolate_i   ( isolate_i  ),
    .isolated_o  ( isolated_o ),
    .cyc_i       ( cyc_i      ),
    .stb_i       ( stb_i      ),
    .we_i        ( we_i       ),
    .adr_i       ( adr_i      ),
    .dat_i       ( dat_i      ),
    .sel_i       ( sel_i      ),
    .ack_o       ( ack_o      ),
    .err_o       ( err_o      ),
    .dat_o       ( dat_o      ),
    .req_full_i  ( req_full   ),
    .req_push_o  ( req_push   ),
    .req_o       ( src_req    ),
    .rsp_empty_i ( rsp_empty  ),
    .rsp_i       ( src_rsp    ),
    .rsp_pop_o   ( rsp_pop    )
  );

  cdc_fifo_gray #(
    .LogDepth   ( LogDepth   ),
    .SyncStages ( SyncStages ),
    .data_t     ( wb_req_t   )
  ) u_req_fifo (
    .wr_clk_i   ( clk_i       ),
    .wr_rst_n_i ( rst_n_i     ),
    .push_i     ( req_push    ),
    .data_i     ( src_req     ),
    .full_o     ( req_full    ),
    .rd_clk_i   ( dst_clk_i   ),
    .rd_rst_n_i ( dst_rst_n_i ),
    .pop_i      ( req_pop     ),
    .empty_o    ( req_empty   ),
    .data_o     ( dst_req     )
  );

  cdc_fifo_gray #(
    .LogDepth   ( LogDepth   ),
    .SyncStages ( SyncStages ),
    .data_t     ( wb_rsp_t   )
  ) u_rsp_fifo (
    .wr_clk_i   ( dst_clk_i   ),
    .wr_rst_n_i ( dst_rst_n_i ),
    .push_i     ( rsp_push    ),
    .data_i     ( dst_rsp     ),
    .full_o     ( rsp_full    ),
    .rd_clk_i   ( clk_i       ),
    .rd_rst_n_i ( rst_n_i     ),
    .pop_i      ( rsp_pop     ),
    .empty_o    ( rsp_empty   ),
    .data_o     ( src_rsp     )
  );

  wb_cdc_dst u_dst (
    .dst_clk_i   ( dst_clk_i   ),
    .dst_rst_n_i ( dst_rst_n_i ),
    .req_empty_i ( req_empty   ),
    .req_i       ( dst_req     ),
    .req_pop_o   ( req_pop     ),
    .rsp_full_i  ( rsp_full    ),
    .rsp_push_o  ( rsp_push    ),
    .rsp_o       ( dst_rsp     ),
    .dst_cyc_o   ( dst_cyc_o   ),
    .dst_stb_o   ( dst_stb_o   ),
    .dst_we_o    ( dst_we_o    ),
    .dst_adr_o   ( dst_adr_o   ),
    .dst_dat_o   ( dst_dat_o   ),
    .dst_sel_o   ( dst_sel_o   ),
    .dst_ack_i   ( dst_ack_i   ),
    .dst_err_i   ( dst_err_i   ),
    .dst_dat_i   ( dst_dat_i   )
  );

endmodule

//--- hw/wb_cdc_dst.sv
// Replays one crossed request at a time and only pops when the response FIFO has room
`timescale 1ns/1ps

module wb_cdc_dst (
  input  logic                             dst_clk_i,
  input  logic                             dst_rst_n_i,
  // Request FIFO read side
  input  logic                             req_empty_i,
  input  wb_cdc_pkg::wb_req_t              req_i,
  output logic                             req_pop_o,
  // Response FIFO write side
  input  logic                             rsp_full_i,
  output logic                             rsp_push_o,
  output wb_cdc_pkg::wb_rsp_t              rsp_o,
  // Wishbone classic master
  output logic                             dst_cyc_o,
  output logic                             dst_stb_o,
  output logic                             dst_we_o,
  output logic [wb_cdc_pkg::AddrWidth-1:0] dst_adr_o,
  output logic [wb_cdc_pkg::DataWidth-1:0] dst_dat_o,
  output logic [wb_cdc_pkg::SelWidth-1:0]  dst_sel_o,
  input  logic                             dst_ack_i,
  input  logic                             dst_err_i,
  input  logic [wb_cdc_pkg::DataWidth-1:0] dst_dat_i
);
  import wb_cdc_pkg::*;

  dst_state_e state_q;
  wb_req_t    req_q;
  logic       bus_done;

  assign req_pop_o = (state_q == DST_IDLE) && !req_empty_i && !rsp_full_i;
  assign bus_done  = (state_q == DST_BUS) && (dst_ack_i || dst_err_i);

  // Room was checked at pop time
  assign rsp_push_o = bus_done;
  assign rsp_o      = '{dat: dst_dat_i, err: dst_err_i};

  always_ff @(posedge dst_clk_i) begin
    if (!dst_rst_n_i) begin
      state_q <= DST_IDLE;
    end else begin
      case (state_q)
        DST_IDLE: begin
          if (req_pop_o) begin
            state_q <= DST_BUS;
          end
        end
        DST_BUS: begin
          if (bus_done) begin
            state_q <= DST_IDLE;
          end
        end
        default: state_q <= DST_IDLE;
      endcase
    end
  end

  // Request is held for the whole bus cycle
  always_ff @(posedge dst_clk_i) begin
    if (req_pop_o) begin
      req_q <= req_i;
    end
  end

  assign dst_cyc_o = (state_q == DST_BUS);
  assign dst_stb_o = (state_q == DST_BUS);
  assign dst_we_o  = req_q.we;
  assign dst_adr_o = req_q.adr;
  assign dst_dat_o = req_q.dat;
  assign dst_sel_o = req_q.sel;

endmodule

//--- hw/wb_cdc_pkg.sv
// Fixed 32-bit address and data with one byte select per byte lane
package wb_cdc_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth  = DataWidth / 8;

  // One request as it crosses to the target side
  typedef struct packed {
    logic [AddrWidth-1:0] adr;
    logic [DataWidth-1:0] dat;
    logic [SelWidth-1:0]  sel;
    logic                 we;
  } wb_req_t;

  // One response as it crosses back to the host side
  typedef struct packed {
    logic [DataWidth-1:0] dat;
    logic                 err;
  } wb_rsp_t;

  // Producer states
  typedef enum logic {
    SRC_IDLE,
    SRC_WAIT
  } src_state_e;

  // Consumer states
  typedef enum logic {
    DST_IDLE,
    DST_BUS
  } dst_state_e;

endpackage

//--- hw/wb_isolate_src.sv
// One cycle in flight at a time and cycles that arrive while isolated end locally with err_o
`timescale 1ns/1ps

module wb_isolate_src (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Isolation control
  input  logic                                isolate_i,
  output logic                                isolated_o,
  // Wishbone classic slave
  input  logic                                cyc_i,
  input  logic                                stb_i,
  input  logic                                we_i,
  input  logic [wb_cdc_pkg::AddrWidth-1:0]    adr_i,
  input  logic [wb_cdc_pkg::DataWidth-1:0]    dat_i,
  input  logic [wb_cdc_pkg::SelWidth-1:0]     sel_i,
  output logic                                ack_o,
  output logic                                err_o,
  output logic [wb_cdc_pkg::DataWidth-1:0]    dat_o,
  // Request FIFO write side
  input  logic                                req_full_i,
  output logic                                req_push_o,
  output wb_cdc_pkg::wb_req_t                 req_o,
  // Response FIFO read side
  input  logic                                rsp_empty_i,
  input  wb_cdc_pkg::wb_rsp_t                 rsp_i,
  output logic                                rsp_pop_o
);
  import wb_cdc_pkg::*;

  src_state_e           state_q;
  logic                 isolated_q;
  logic                 ack_q;
  logic                 err_q;
  logic [DataWidth-1:0] dat_q;
  logic                 new_cyc;
  logic                 iso_term;

  // Still open in the ack or err clock, so that clock does not count
  assign new_cyc  = cyc_i && stb_i && !ack_q && !err_q;
  assign iso_term = (state_q == SRC_IDLE) && isolated_q && new_cyc;

  assign req_push_o = (state_q == SRC_IDLE) && !isolated_q && new_cyc && !req_full_i;
  assign req_o      = '{adr: adr_i, dat: dat_i, sel: sel_i, we: we_i};
  assign rsp_pop_o  = (state_q == SRC_WAIT) && !rsp_empty_i;

  assign isolated_o = isolated_q;
  assign ack_o      = ack_q;
  assign err_o      = err_q;
  assign dat_o      = dat_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= SRC_IDLE;
      isolated_q <= 1'b0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      case (state_q)
        SRC_IDLE: begin
          if (isolated_q) begin
            isolated_q <= isolate_i;
            if (new_cyc) begin
              err_q <= 1'b1;
            end
          end else if (req_push_o) begin
            state_q <= SRC_WAIT;
          end else if (isolate_i && !new_cyc) begin
            // Only isolate with no cycle pending
            isolated_q <= 1'b1;
          end
        end
        SRC_WAIT: begin
          if (rsp_pop_o) begin
            ack_q   <= !rsp_i.err;
            err_q   <= rsp_i.err;
            state_q <= SRC_IDLE;
          end
        end
        default: state_q <= SRC_IDLE;
      endcase
    end
  end

  // Read data for the response clock
  always_ff @(posedge clk_i) begin
    if (rsp_pop_o) begin
      dat_q <= rsp_i.dat;
    end else if (iso_term) begin
      dat_q <= '0;
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f wb_cdc_bridge.f \
  --top-module tb_wb_cdc_bridge > build.log 2>&1 \
  || { cat build.log; echo "Verilator build error"; exit 1; }
./obj_dir/Vtb_wb_cdc_bridge > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "test passed" sim.log && { echo "Simulation passed"; exit 0; }
echo "Simulation ended without a result, see sim.log"
exit 1

//--- testbench/tb_wb_cdc_bridge.sv
// One host and one target model, fixed seed, stops at the first mismatch, target memory uses adr[9:2]
`timescale 1ns/1ps

module tb_wb_cdc_bridge;
  import wb_cdc_pkg::*;

  localparam int TimeoutCycles = 200;

  logic                 clk_i, rst_n_i, dst_clk_i, dst_rst_n_i;
  logic                 isolate_i, isolated_o;
  logic                 cyc_i, stb_i, we_i, ack_o, err_o;
  logic [AddrWidth-1:0] adr_i;
  logic [DataWidth-1:0] dat_i, dat_o;
  logic [SelWidth-1:0]  sel_i;
  logic                 dst_cyc_o, dst_stb_o, dst_we_o, dst_ack_i, dst_err_i;
  logic [AddrWidth-1:0] dst_adr_o;
  logic [DataWidth-1:0] dst_dat_o, dst_dat_i;
  logic [SelWidth-1:0]  dst_sel_o;

  integer               seed = 48;
  logic [31:0]          tgt_mem [256];
  logic [31:0]          ref_mem [256];
  wb_req_t              exp_req;
  int unsigned          tgt_delay;
  logic                 max_delay;
  int                   dst_cycles;

  wb_cdc_bridge #(
    .LogDepth   ( 3 ),
    .SyncStages ( 2 )
  ) u_wb_cdc_bridge (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .dst_clk_i   ( dst_clk_i   ),
    .dst_rst_n_i ( dst_rst_n_i ),
    .isolate_i   ( isolate_i   ),
    .isolated_o  ( isolated_o  ),
    .cyc_i       ( cyc_i       ),
    .stb_i       ( stb_i       ),
    .we_i        ( we_i        ),
    .adr_i       ( adr_i       ),
    .dat_i       ( dat_i       ),
    .sel_i       ( sel_i       ),
    .ack_o       ( ack_o       ),
    .err_o       ( err_o       ),
    .dat_o       ( dat_o       ),
    .dst_cyc_o   ( dst_cyc_o   ),
    .dst_stb_o   ( dst_stb_o   ),
    .dst_we_o    ( dst_we_o    ),
    .dst_adr_o   ( dst_adr_o   ),
    .dst_dat_o   ( dst_dat_o   ),
    .dst_sel_o   ( dst_sel_o   ),
    .dst_ack_i   ( dst_ack_i   ),
    .dst_err_i   ( dst_err_i   ),
    .dst_dat_i   ( dst_dat_i   )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    dst_clk_i = 1'b0;
    forever #7 dst_clk_i = ~dst_clk_i;
  end

  // Distinct start value for every word
  function automatic logic [31:0] fill_word(input int unsigned i);
    return (32'(i) * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] act,
                                 input logic [31:0] exp);
    $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, act, exp);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, TimeoutCycles);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) report_mismatch(name, 32'(act), 32'(exp));
  endtask

  task automatic check_rsp(input wb_rsp_t exp);
    if (dat_o !== exp.dat) report_mismatch("dat_o", dat_o, exp.dat);
    if (err_o !== exp.err) report_mismatch("err_o", 32'(err_o), 32'(exp.err));
    if (ack_o !== !exp.err) report_mismatch("ack_o", 32'(ack_o), 32'(!exp.err));
  endtask

  task automatic check_req(input wb_req_t exp);
    if (dst_adr_o !== exp.adr) report_mismatch("dst_adr_o", dst_adr_o, exp.adr);
    if (dst_dat_o !== exp.dat) report_mismatch("dst_dat_o", dst_dat_o, exp.dat);
    if (dst_sel_o !== exp.sel) report_mismatch("dst_sel_o", 32'(dst_sel_o), 32'(exp.sel));
    if (dst_we_o !== exp.we) report_mismatch("dst_we_o", 32'(dst_we_o), 32'(exp.we));
  endtask

  task automatic step_clk();
    @(posedge clk_i);
    #1;
  endtask

  task automatic random_req(input logic to_err, output wb_req_t req);
    req.adr     = $random(seed);
    req.adr[1:0] = 2'b00;
    req.adr[31] = to_err;
    req.dat     = $random(seed);
    req.sel     = 4'($random(seed));
    req.we      = 1'($random(seed));
  endtask

  // Writes update selected lanes, reads return selected lanes only
  task automatic predict_rsp(input wb_req_t req, output wb_rsp_t exp);
    logic [7:0] idx;
    idx     = req.adr[9:2];
    exp.dat = '0;
    exp.err = 1'b0;
    for (int b = 0; b < 4; b++) begin
      if (req.adr[31]) begin
        exp.err = 1'b1;
      end else if (req.sel[b] && req.we) begin
        ref_mem[idx][8*b +: 8] = req.dat[8*b +: 8];
      end else if (req.sel[b]) begin
        exp.dat[8*b +: 8] = ref_mem[idx][8*b +: 8];
      end
    end
  endtask

  task automatic start_cycle(input wb_req_t req);
    step_clk();
    exp_req   = req;
    tgt_delay = max_delay ? 32'd3 : $unsigned($random(seed)) % 4;
    cyc_i     = 1'b1;
    stb_i     = 1'b1;
    we_i      = req.we;
    adr_i     = req.adr;
    dat_i     = req.dat;
    sel_i     = req.sel;
  endtask

  task automatic finish_cycle(input wb_rsp_t exp);
    int n;
    n = 0;
    step_clk();
    while (ack_o !== 1'b1 && err_o !== 1'b1) begin
      if (n >= TimeoutCycles) report_timeout("ack_o or err_o");
      step_clk();
      n++;
    end
    check_rsp(exp);
    cyc_i = 1'b0;
    stb_i = 1'b0;
  endtask

  task automatic run_cycle(input wb_req_t req);
    wb_rsp_t exp;
    predict_rsp(req, exp);
    start_cycle(req);
    finish_cycle(exp);
  endtask

  task automatic wait_isolated(input logic level);
    int n;
    n = 0;
    while (isolated_o !== level) begin
      if (n >= TimeoutCycles) report_timeout("change of isolated_o");
      step_clk();
      n++;
    end
  endtask

  task automatic run_random(input int count);
    wb_req_t req;
    repeat (count) begin
      random_req(1'b0, req);
      run_cycle(req);
    end
  endtask

  // Target memory with 0 to 3 clocks of ack delay
  initial begin : target_model
    logic [7:0] idx;
    int         i;
    dst_rst_n_i = 1'b0;
    dst_ack_i   = 1'b0;
    dst_err_i   = 1'b0;
    dst_dat_i   = '0;
    dst_cycles  = 0;
    for (i = 0; i < 256; i++) tgt_mem[i] = fill_word(i);
    repeat (3) @(posedge dst_clk_i);
    #1;
    dst_rst_n_i = 1'b1;
    forever begin
      @(posedge dst_clk_i);
      #1;
      dst_ack_i = 1'b0;
      dst_err_i = 1'b0;
      dst_dat_i = '0;
      if (dst_cyc_o === 1'b1) begin
        dst_cycles++;
        check_bit("dst_stb_o", dst_stb_o, 1'b1);
        check_req(exp_req);
        repeat (tgt_delay) begin
          @(posedge dst_clk_i);
          #1;
        end
        idx = dst_adr_o[9:2];
        if (dst_adr_o[31]) begin
          dst_err_i = 1'b1;
        end else begin
          dst_ack_i = 1'b1;
          for (int b = 0; b < 4; b++) begin
            if (dst_sel_o[b] && dst_we_o) tgt_mem[idx][8*b +: 8] = dst_dat_o[8*b +: 8];
            else if (dst_sel_o[b]) dst_dat_i[8*b +: 8] = tgt_mem[idx][8*b +: 8];
          end
        end
      end
    end
  end

  initial begin : stimulus
    wb_req_t req;
    wb_rsp_t iso_rsp;
    int      n;
    int      cnt;
    rst_n_i   = 1'b0;
    isolate_i = 1'b0;
    cyc_i     = 1'b0;
    stb_i     = 1'b0;
    we_i      = 1'b0;
    adr_i     = '0;
    dat_i     = '0;
    sel_i     = '0;
    max_delay = 1'b0;
    iso_rsp.dat = '0;
    iso_rsp.err = 1'b1;
    for (n = 0; n < 256; n++) ref_mem[n] = fill_word(n);
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    n = 0;
    while (dst_rst_n_i !== 1'b1) begin
      if (n >= TimeoutCycles) report_timeout("target reset release");
      step_clk();
      n++;
    end

    // Quiet after reset
    repeat (10) begin
      step_clk();
      check_bit("ack_o", ack_o, 1'b0);
      check_bit("err_o", err_o, 1'b0);
      check_bit("isolated_o", isolated_o, 1'b0);
      check_bit("dst_cyc_o", dst_cyc_o, 1'b0);
      check_bit("dst_stb_o", dst_stb_o, 1'b0);
    end

    run_random(200);

    // Error target, then confirm the word is untouched
    random_req(1'b1, req);
    req.we  = 1'b1;
    req.sel = 4'hf;
    // Data that differs from the stored word in every bit
    req.dat = ~ref_mem[req.adr[9:2]];
    run_cycle(req);
    req.adr[31] = 1'b0;
    req.we      = 1'b0;
    req.sel     = 4'hf;
    run_cycle(req);

    // Isolate while idle
    isolate_i = 1'b1;
    wait_isolated(1'b1);
    cnt = dst_cycles;
    repeat (5) begin
      random_req(1'b0, req);
      start_cycle(req);
      finish_cycle(iso_rsp);
    end
    check_bit("dst_cyc_o", dst_cycles != cnt, 1'b0);
    isolate_i = 1'b0;
    step_clk();
    check_bit("isolated_o", isolated_o, 1'b0);

    // Isolate while a cycle is open
    random_req(1'b0, req);
    predict_rsp(req, iso_rsp);
    start_cycle(req);
    isolate_i = 1'b1;
    finish_cycle(iso_rsp);
    check_bit("isolated_o", isolated_o, 1'b0);
    wait_isolated(1'b1);
    isolate_i = 1'b0;
    step_clk();
    check_bit("isolated_o", isolated_o, 1'b0);
    run_random(20);

    max_delay = 1'b1;
    run_random(40);

    $display("test passed");
    $finish;
  end

endmodule

//--- wb_cdc_bridge.f
hw/wb_cdc_pkg.sv
hw/cdc_fifo_gray.sv
hw/wb_isolate_src.sv
hw/wb_cdc_dst.sv
hw/wb_cdc_bridge.sv
testbench/tb_wb_cdc_bridge.sv
